// ==== flist.f ====
+incdir+include
logic/lane_pkg.sv
logic/lane_aux_chain.sv
logic/lane_alu_slice.sv
logic/lane_result_merge.sv
logic/lane_unit_top.sv
dv/lane_unit_assertions.sv
dv/lane_unit_tb.sv

// ==== dv/lane_unit_tb.sv ====
// Directed testbench for the multi-lane integer arithmetic unit.
// Each test task drives requests into the DUT, and a monitor compares every
// response taken at the output against a reference model built from the
// opcode and lane rules. The run stops at the first error.

`timescale 1ns/1ps
`default_nettype none

`include "lane_macros.svh"

module lane_unit_tb;

  localparam int TAG_W          = `LANE_TAG_WIDTH;
  localparam int N_LANES        = `LANE_NUM_LANES;
  localparam int TIMEOUT_CYCLES = 200;
  // Signed range of one lane word
  localparam int LANE_MAX = (1 << (`LANE_WIDTH - 1)) - 1;
  localparam int LANE_MIN = -(1 << (`LANE_WIDTH - 1));

  logic                clk_i = 1'b0;
  logic                reset_i;
  lane_pkg::lane_req_t req_i;
  logic                req_valid_i;
  logic                req_ready_o;
  logic                flush_i;
  lane_pkg::lane_rsp_t rsp_o;
  logic                rsp_valid_o;
  logic                rsp_ready_i;
  logic                busy_o;

  // Expected responses in acceptance order
  lane_pkg::lane_rsp_t expected_q[$];
  int                  cycle_count = 0;
  int                  accept_cycle;
  int                  rsp_cycle;
  int                  rsp_count = 0;
  int                  error_count = 0;
  logic                last_overflow;

  lane_unit_top DUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .flush_i     (flush_i),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .busy_o      (busy_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_count++;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic fail_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch %s: actual 0x%0h expected 0x%0h", name, actual, expected));
    end
  endtask

  // Reference model that works on signed lane values and wraps results
  // to the lane width. Overflow means the exact result left the signed range
  function automatic lane_pkg::lane_rsp_t expected_rsp(input lane_pkg::lane_req_t req);
    lane_pkg::lane_rsp_t rsp;
    int                  sa;
    int                  sb;
    int                  exact;
    logic                active;
    rsp           = '0;
    rsp.tag       = req.ctrl.tag;
    rsp.op        = req.ctrl.op;
    rsp.is_vector = req.ctrl.is_vector;
    for (int l = 0; l < N_LANES; l++) begin
      active = req.ctrl.lane_mask[l] && (req.ctrl.is_vector || l == 0);
      rsp.lane_mask[l] = active;
      sa = $signed(req.a[l]);
      sb = $signed(req.b[l]);
      case (req.ctrl.op)
        lane_pkg::OP_ADD: exact = sa + sb;
        lane_pkg::OP_SUB: exact = sa - sb;
        lane_pkg::OP_MIN: exact = (sa < sb) ? sa : sb;
        default:          exact = (sa > sb) ? sa : sb;
      endcase
      if (active) begin
        rsp.result[l] = exact[`LANE_WIDTH-1:0];
        if (exact > LANE_MAX || exact < LANE_MIN) begin
          rsp.overflow = 1'b1;
        end
      end
    end
    return rsp;
  endfunction

  function automatic lane_pkg::lane_req_t random_req(input logic [TAG_W-1:0] tag,
      input lane_pkg::lane_op_e op, input logic is_vector, input logic [N_LANES-1:0] mask);
    lane_pkg::lane_req_t req;
    req.ctrl.tag       = tag;
    req.ctrl.op        = op;
    req.ctrl.is_vector = is_vector;
    req.ctrl.lane_mask = mask;
    for (int l = 0; l < N_LANES; l++) begin
      req.a[l] = `LANE_WIDTH'($urandom());
      req.b[l] = `LANE_WIDTH'($urandom());
    end
    return req;
  endfunction

  task automatic compare_rsp(input lane_pkg::lane_rsp_t exp_rsp);
    check_value("rsp_o.tag", rsp_o.tag, exp_rsp.tag);
    check_value("rsp_o.op", rsp_o.op, exp_rsp.op);
    check_value("rsp_o.is_vector", rsp_o.is_vector, exp_rsp.is_vector);
    check_value("rsp_o.lane_mask", rsp_o.lane_mask, exp_rsp.lane_mask);
    check_value("rsp_o.result", rsp_o.result, exp_rsp.result);
    check_value("rsp_o.overflow", rsp_o.overflow, exp_rsp.overflow);
  endtask

  // Every response taken at the output must match the oldest expected one
  always @(negedge clk_i) begin
    if (!reset_i && rsp_valid_o && rsp_ready_i) begin
      if (expected_q.size() == 0) begin
        fail_run("a response was taken while no request was outstanding");
      end else begin
        compare_rsp(expected_q.pop_front());
        last_overflow = rsp_o.overflow;
        rsp_cycle     = cycle_count;
        rsp_count++;
      end
    end
  end

  // Presents one request and returns one drive delay after its acceptance
  task automatic send_req(input lane_pkg::lane_req_t req, input logic expect_rsp);
    int waited;
    waited      = 0;
    req_i       = req;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        fail_run("request handshake never completed, req_ready_o stayed low");
      end
      @(negedge clk_i);
    end
    accept_cycle = cycle_count;
    if (expect_rsp) begin
      expected_q.push_back(expected_rsp(req));
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        fail_run("expected responses never arrived at the output");
      end
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  // One scalar request per opcode, only lane 0 may carry a result
  task automatic scalar_test();
    lane_pkg::lane_req_t req;
    rsp_ready_i = 1'b1;
    for (int op = 0; op < 4; op++) begin
      req = random_req(TAG_W'(op), lane_pkg::lane_op_e'(op), 1'b0, '1);
      send_req(req, 1'b1);
      wait_drain();
      check_value("response latency", rsp_cycle - accept_cycle, `LANE_NUM_PIPE_REGS);
    end
  endtask

  task automatic vector_test();
    lane_pkg::lane_req_t req;
    rsp_ready_i = 1'b1;
    for (int i = 0; i < 8; i++) begin
      req = random_req(TAG_W'(i), lane_pkg::lane_op_e'($urandom_range(3, 0)), 1'b1,
                       N_LANES'($urandom()));
      send_req(req, 1'b1);
    end
    wait_drain();
    // Most positive value plus one in lane 2 while every lane is active
    req = random_req(TAG_W'(8), lane_pkg::OP_ADD, 1'b1, 4'b1111);
    req.a    = '0;
    req.b    = '0;
    req.a[2] = 16'h7fff;
    req.b[2] = 16'h0001;
    send_req(req, 1'b1);
    wait_drain();
    check_value("rsp_o.overflow active lane", last_overflow, 1'b1);
    // Lane 2 masked off still holds the overflow of the item before
    req.ctrl.lane_mask = 4'b1011;
    req.ctrl.tag       = TAG_W'(9);
    send_req(req, 1'b1);
    wait_drain();
    check_value("rsp_o.overflow masked lane", last_overflow, 1'b0);
  endtask

  task automatic stream_test();
    lane_pkg::lane_req_t req;
    logic [15:0]         pattern;
    int                  in_flight;
    int                  start_count;
    int                  waited;
    pattern     = 16'b1011_0011_1000_1101;
    start_count = rsp_count;
    in_flight   = 0;
    waited      = 0;
    fork
      begin
        for (int i = 0; i < 10; i++) begin
          req = random_req(TAG_W'(i), lane_pkg::lane_op_e'($urandom_range(3, 0)), 1'b1,
                           N_LANES'($urandom()));
          send_req(req, 1'b1);
        end
      end
      begin
        while (rsp_count - start_count < 10) begin
          rsp_ready_i = pattern[waited % 16];
          @(negedge clk_i);
          // Input stalls only with all stages full and the output blocked
          check_value("req_ready_o", req_ready_o,
                      !(in_flight == `LANE_NUM_PIPE_REGS && !rsp_ready_i));
          in_flight = in_flight + int'(req_valid_i && req_ready_o)
                                - int'(rsp_valid_o && rsp_ready_i);
          @(posedge clk_i);
          #1;
          waited++;
          if (waited > TIMEOUT_CYCLES) begin
            fail_run("streamed responses did not all arrive");
          end
        end
      end
    join
    rsp_ready_i = 1'b1;
  endtask

  task automatic flush_test();
    lane_pkg::lane_req_t req;
    rsp_ready_i = 1'b0;
    for (int i = 0; i < 2; i++) begin
      req = random_req(TAG_W'(i), lane_pkg::OP_SUB, 1'b1, 4'hf);
      send_req(req, 1'b0);
    end
    @(negedge clk_i);
    check_value("rsp_valid_o", rsp_valid_o, 1'b1);
    check_value("req_ready_o", req_ready_o, 1'b0);
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      check_value("rsp_valid_o", rsp_valid_o, 1'b0);
      check_value("busy_o", busy_o, 1'b0);
      @(posedge clk_i);
      #1;
    end
    rsp_ready_i = 1'b1;
    req = random_req(TAG_W'(5), lane_pkg::OP_MAX, 1'b1, 4'b0101);
    send_req(req, 1'b1);
    wait_drain();
  endtask

  task automatic busy_test();
    lane_pkg::lane_req_t req;
    int                  waited;
    logic                taken;
    logic                accepted;
    rsp_ready_i = 1'b1;
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);
    @(posedge clk_i);
    #1;
    req = random_req(TAG_W'(11), lane_pkg::OP_MIN, 1'b1, 4'b0110);
    req_i       = req;
    req_valid_i = 1'b1;
    expected_q.push_back(expected_rsp(req));
    taken  = 1'b0;
    waited = 0;
    // Busy holds from presentation until the response leaves
    while (!taken) begin
      @(negedge clk_i);
      check_value("busy_o", busy_o, 1'b1);
      taken    = rsp_valid_o && rsp_ready_i;
      accepted = req_valid_i && req_ready_o;
      @(posedge clk_i);
      #1;
      if (accepted) begin
        req_valid_i = 1'b0;
      end
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        fail_run("busy test response never arrived");
      end
    end
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);
    @(posedge clk_i);
    #1;
  endtask

  // --------------------------------------------------
  // Run
  // --------------------------------------------------

  initial begin
    int unsigned seed;
    seed        = 5599;
    reset_i     = 1'b1;
    req_i       = '0;
    req_valid_i = 1'b0;
    flush_i     = 1'b0;
    rsp_ready_i = 1'b1;
    void'($urandom(seed));
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(posedge clk_i);
    #1;
    scalar_test();
    vector_test();
    stream_test();
    flush_test();
    busy_test();
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/lane_unit_assertions.sv ====
// Concurrent checks on the lane unit's response handshake, flush and busy.
// Bound into every lane_unit_top instance, so no testbench wiring is needed.

`timescale 1ns/1ps
`default_nettype none

module lane_unit_assertions (
  input logic                clk_i,
  input logic                reset_i,
  input logic                flush_i,
  input lane_pkg::lane_rsp_t rsp_i,
  input logic                rsp_valid_i,
  input logic                rsp_ready_i,
  input logic                busy_i
);

  // A stalled response keeps valid and data until the consumer takes it
  stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (rsp_valid_i && !rsp_ready_i && !flush_i) |=> (rsp_valid_i && $stable(rsp_i)))
    else $error("response valid or data changed while stalled");

  // Reset leaves the pipe empty
  busy_after_reset: assert property (@(posedge clk_i) reset_i |=> !busy_i)
    else $error("busy high right after reset");

  // Flush drops the item at the output on the next edge
  flush_clears: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |=> !rsp_valid_i)
    else $error("response still valid after flush");

endmodule

bind lane_unit_top lane_unit_assertions u_assertions (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .flush_i     (flush_i),
  .rsp_i       (rsp_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .busy_i      (busy_o)
);

`default_nettype wire

// ==== logic/lane_unit_top.sv ====
// Top level of the pipelined multi-lane integer arithmetic unit.
// Requests enter with a valid/ready handshake and leave as responses
// LANE_NUM_PIPE_REGS cycles later when the consumer keeps up. A flush
// drops everything in flight, and busy shows whether any item is inside.

`timescale 1ns/1ps
`default_nettype none

`include "lane_macros.svh"

module lane_unit_top (
  input  logic                clk_i,
  input  logic                reset_i,
  // Request side
  input  lane_pkg::lane_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic                flush_i,
  // Response side
  output lane_pkg::lane_rsp_t rsp_o,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output logic                busy_o
);

  // Control word leaving the chain, aligned with the lane outputs
  lane_pkg::lane_ctrl_t                                 out_ctrl;
  logic [`LANE_NUM_LANES-1:0][`LANE_NUM_PIPE_REGS-1:0] lane_reg_enable;
  logic [`LANE_NUM_LANES-1:0][`LANE_WIDTH-1:0]         lane_result;
  logic [`LANE_NUM_LANES-1:0]                           lane_overflow;

  // Handshake, control and lane enables
  lane_aux_chain u_aux_chain (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .ctrl_i            (req_i.ctrl),
    .valid_i           (req_valid_i),
    .ready_o           (req_ready_o),
    .flush_i           (flush_i),
    .ctrl_o            (out_ctrl),
    .valid_o           (rsp_valid_o),
    .ready_i           (rsp_ready_i),
    .lane_reg_enable_o (lane_reg_enable),
    .busy_o            (busy_o)
  );

  // One datapath slice per lane, each driven by its own enables
  for (genvar l = 0; l < `LANE_NUM_LANES; l++) begin : gen_lane
    lane_alu_slice u_alu_slice (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .op_i         (req_i.ctrl.op),
      .a_i          (req_i.a[l]),
      .b_i          (req_i.b[l]),
      .reg_enable_i (lane_reg_enable[l]),
      .result_o     (lane_result[l]),
      .overflow_o   (lane_overflow[l])
    );
  end

  // Response assembly
  lane_result_merge u_result_merge (
    .ctrl_i     (out_ctrl),
    .result_i   (lane_result),
    .overflow_i (lane_overflow),
    .rsp_o      (rsp_o)
  );

endmodule

`default_nettype wire

// ==== logic/lane_result_merge.sv ====
// Output merge of the lane unit.
// Joins the control word from the end of the chain with the lane outputs
// into one response. Lanes that took no part in the item hold stale values,
// so their results are forced to zero and their overflow is ignored.

`timescale 1ns/1ps
`default_nettype none

`include "lane_macros.svh"

module lane_result_merge (
  input  lane_pkg::lane_ctrl_t                        ctrl_i,
  input  logic [`LANE_NUM_LANES-1:0][`LANE_WIDTH-1:0] result_i,
  input  logic [`LANE_NUM_LANES-1:0]                  overflow_i,
  output lane_pkg::lane_rsp_t                         rsp_o
);

  // Overflow bits of the lanes that were active for this item
  logic [`LANE_NUM_LANES-1:0] active_overflow;

  // Only add and subtract can report overflow
  logic is_arith;

  assign active_overflow = overflow_i & ctrl_i.lane_mask;

  assign is_arith = (ctrl_i.op == lane_pkg::OP_ADD) ||
                    (ctrl_i.op == lane_pkg::OP_SUB);

  always_comb begin
    // Control fields pass straight through, the mask is already the effective one
    rsp_o.tag       = ctrl_i.tag;
    rsp_o.op        = ctrl_i.op;
    rsp_o.is_vector = ctrl_i.is_vector;
    rsp_o.lane_mask = ctrl_i.lane_mask;

    // Inactive lanes read zero
    for (int l = 0; l < `LANE_NUM_LANES; l++) begin
      if (ctrl_i.lane_mask[l]) begin
        rsp_o.result[l] = result_i[l];
      end else begin
        rsp_o.result[l] = '0;
      end
    end

    rsp_o.overflow = is_arith & (|active_overflow);
  end

endmodule

`default_nettype wire

// ==== logic/lane_alu_slice.sv ====
// Datapath of a single lane.
// Computes add, subtract, min or max on one operand pair in the input stage
// and carries the result through the register stages. Each stage only loads
// when the control chain enables it for this lane, so an idle lane keeps
// its old values and does not toggle.

`timescale 1ns/1ps
`default_nettype none

`include "lane_macros.svh"

module lane_alu_slice (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  lane_pkg::lane_op_e             op_i,
  input  logic [`LANE_WIDTH-1:0]         a_i,
  input  logic [`LANE_WIDTH-1:0]         b_i,
  input  logic [`LANE_NUM_PIPE_REGS-1:0] reg_enable_i,
  output logic [`LANE_WIDTH-1:0]         result_o,
  output logic                           overflow_o
);

  // --------------------------------------------------
  // Arithmetic
  // --------------------------------------------------

  logic [`LANE_WIDTH-1:0] sum;
  logic [`LANE_WIDTH-1:0] diff;
  logic                   sum_ovf;
  logic                   diff_ovf;
  logic                   a_lt_b;
  logic [`LANE_WIDTH-1:0] result_d;
  logic                   overflow_d;

  // Both wrap to the lane width
  assign sum  = a_i + b_i;
  assign diff = a_i - b_i;

  // Addition overflows when equal signs give a result of the other sign
  assign sum_ovf = (a_i[`LANE_WIDTH-1] == b_i[`LANE_WIDTH-1]) &&
                   (sum[`LANE_WIDTH-1] != a_i[`LANE_WIDTH-1]);

  // Subtraction overflows when differing signs flip the sign of a
  assign diff_ovf = (a_i[`LANE_WIDTH-1] != b_i[`LANE_WIDTH-1]) &&
                    (diff[`LANE_WIDTH-1] != a_i[`LANE_WIDTH-1]);

  // Signed compare shared by min and max
  assign a_lt_b = $signed(a_i) < $signed(b_i);

  always_comb begin
    result_d   = sum;
    overflow_d = 1'b0;
    unique case (op_i)
      lane_pkg::OP_ADD: begin
        result_d   = sum;
        overflow_d = sum_ovf;
      end
      lane_pkg::OP_SUB: begin
        result_d   = diff;
        overflow_d = diff_ovf;
      end
      // Min and max pick one of the inputs, they cannot overflow
      lane_pkg::OP_MIN: result_d = a_lt_b ? a_i : b_i;
      lane_pkg::OP_MAX: result_d = a_lt_b ? b_i : a_i;
      default: begin
        result_d   = sum;
        overflow_d = 1'b0;
      end
    endcase
  end

  // --------------------------------------------------
  // Enable-gated stages
  // --------------------------------------------------

  // Index i holds the value after i register stages
  logic [0:`LANE_NUM_PIPE_REGS][`LANE_WIDTH-1:0] result;
  logic [0:`LANE_NUM_PIPE_REGS]                  overflow;

  assign result[0]   = result_d;
  assign overflow[0] = overflow_d;

  for (genvar i = 0; i < `LANE_NUM_PIPE_REGS; i++) begin : gen_stage
    always_ff @(posedge clk_i) begin
      if (reg_enable_i[i]) begin
        result[i+1] <= result[i];
      end
    end

    // Overflow flags start cleared
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        overflow[i+1] <= 1'b0;
      end else if (reg_enable_i[i]) begin
        overflow[i+1] <= overflow[i];
      end
    end
  end

  assign result_o   = result[`LANE_NUM_PIPE_REGS];
  assign overflow_o = overflow[`LANE_NUM_PIPE_REGS];

endmodule

`default_nettype wire

// ==== logic/lane_aux_chain.sv ====
// Shared control chain of the lane unit.
// Carries the control word and the valid bit through the register stages
// with a valid/ready handshake, and hands every lane one register enable
// per stage so the lane datapaths stay aligned with the chain. Lanes that
// are not active for an item get no enable, so their registers stay still.

`timescale 1ns/1ps
`default_nettype none

`include "lane_macros.svh"

module lane_aux_chain (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  // Upstream side
  input  lane_pkg::lane_ctrl_t                                 ctrl_i,
  input  logic                                                 valid_i,
  output logic                                                 ready_o,
  input  logic                                                 flush_i,
  // Downstream side
  output lane_pkg::lane_ctrl_t                                 ctrl_o,
  output logic                                                 valid_o,
  input  logic                                                 ready_i,
  // Register enables, one vector per lane with one bit per stage
  output logic [`LANE_NUM_LANES-1:0][`LANE_NUM_PIPE_REGS-1:0] lane_reg_enable_o,
  // High while any stage holds a valid item
  output logic                                                 busy_o
);

  // --------------------------------------------------
  // Stage 0 control word
  // --------------------------------------------------

  // Control word after mask qualification, before the first register
  lane_pkg::lane_ctrl_t ctrl_eff;

  // Scalar requests only ever use lane 0, whatever the mask says
  always_comb begin
    ctrl_eff = ctrl_i;
    if (!ctrl_i.is_vector) begin
      ctrl_eff.lane_mask = {{(`LANE_NUM_LANES-1){1'b0}}, ctrl_i.lane_mask[0]};
    end
  end

  // --------------------------------------------------
  // Pipeline stages
  // --------------------------------------------------

  // Index i holds the item after i register stages, index 0 is the input
  lane_pkg::lane_ctrl_t [0:`LANE_NUM_PIPE_REGS] ctrl;
  logic                 [0:`LANE_NUM_PIPE_REGS] valid;
  logic                 [0:`LANE_NUM_PIPE_REGS] ready;

  assign ctrl[0]  = ctrl_eff;
  assign valid[0] = valid_i;

  // The last stage is released by the consumer
  assign ready[`LANE_NUM_PIPE_REGS] = ready_i;

  for (genvar i = 0; i < `LANE_NUM_PIPE_REGS; i++) begin : gen_stage

    // Stage i moves its item forward on this edge
    logic stage_en;

    // A stage may advance when the next one drains or only holds a bubble,
    // which lets bubbles collapse under back-pressure
    assign ready[i] = ready[i+1] | ~valid[i+1];

    assign stage_en = ready[i] & valid[i];

    // Valid follows ready, flush drops every item in flight at the next edge
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid[i+1] <= valid[i];
      end
    end

    // Control word only loads when a real item moves forward
    always_ff @(posedge clk_i) begin
      if (stage_en) begin
        ctrl[i+1] <= ctrl[i];
      end
    end

    // Each lane sees the stage enable only when it takes part in this item
    for (genvar l = 0; l < `LANE_NUM_LANES; l++) begin : gen_lane_en
      assign lane_reg_enable_o[l][i] = stage_en & ctrl[i].lane_mask[l];
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------

  assign ready_o = ready[0];
  assign ctrl_o  = ctrl[`LANE_NUM_PIPE_REGS];
  assign valid_o = valid[`LANE_NUM_PIPE_REGS];

  // The input stage counts too, so busy rises as soon as a request is presented
  assign busy_o = |valid;

endmodule

`default_nettype wire

// ==== logic/lane_pkg.sv ====
// Shared types of the multi-lane integer arithmetic unit.
// Modules refer to these types by scoped name, e.g. lane_pkg::lane_req_t.
// Sizes come from the lane macros header.

`default_nettype none

`include "lane_macros.svh"

package lane_pkg;

  // Arithmetic operation applied to every active lane
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MIN = 2'd2,
    OP_MAX = 2'd3
  } lane_op_e;

  // Control word that travels down the shared chain next to the lane data
  typedef struct packed {
    logic [`LANE_TAG_WIDTH-1:0] tag;
    lane_op_e                   op;
    logic                       is_vector;
    logic [`LANE_NUM_LANES-1:0] lane_mask;
  } lane_ctrl_t;

  // One request with its control word and one operand pair per lane
  typedef struct packed {
    lane_ctrl_t                                  ctrl;
    logic [`LANE_NUM_LANES-1:0][`LANE_WIDTH-1:0] a;
    logic [`LANE_NUM_LANES-1:0][`LANE_WIDTH-1:0] b;
  } lane_req_t;

  // Response with the effective mask, lane results and a merged overflow
  typedef struct packed {
    logic [`LANE_TAG_WIDTH-1:0]                  tag;
    lane_op_e                                    op;
    logic                                        is_vector;
    logic [`LANE_NUM_LANES-1:0]                  lane_mask;
    logic [`LANE_NUM_LANES-1:0][`LANE_WIDTH-1:0] result;
    logic                                        overflow;
  } lane_rsp_t;

endpackage

`default_nettype wire

// ==== include/lane_macros.svh ====
// Build-time constants for the multi-lane integer arithmetic unit.
// Include this header wherever lane count, lane width, pipeline depth or
// tag width is needed. The package builds its types from these values.

`ifndef LANE_MACROS_SVH
`define LANE_MACROS_SVH

// Number of parallel lanes in one request
`define LANE_NUM_LANES 4

// Bits per lane operand and per lane result
`define LANE_WIDTH 16

// Register stages between request and response, 1 to 3 are supported
`define LANE_NUM_PIPE_REGS 2

// Bits of the request tag that is returned with the response
`define LANE_TAG_WIDTH 4

`endif
